// ==== design/game_pkg.sv ====
package game_pkg;

    localparam int BOARD_W = 10;   // cells per board side
    localparam int POS_W   = 4;    // one board coordinate
    localparam int TROOP_W = 9;    // default troop counter width
    localparam int STEP_W  = 12;   // moves played, two per round

    // every 16th round all player cells grow, not only cities and crowns
    localparam int GROWTH_PERIOD_LOG2 = 4;

    localparam logic [POS_W-1:0] RED_CROWN_H  = 4'd2;
    localparam logic [POS_W-1:0] RED_CROWN_V  = 4'd3;
    localparam logic [POS_W-1:0] BLUE_CROWN_H = 4'd8;
    localparam logic [POS_W-1:0] BLUE_CROWN_V = 4'd7;

    typedef enum logic [1:0] {NPC, RED, BLUE} player_t;

    typedef enum logic [1:0] {TERRITORY, MOUNTAIN, CROWN, CITY} piece_t;

    typedef enum logic [2:0] {
        KEY_W     = 3'd0,
        KEY_A     = 3'd1,
        KEY_S     = 3'd2,
        KEY_D     = 3'd3,
        KEY_SPACE = 3'd4,
        KEY_Z     = 3'd5,
        KEY_NONE  = 3'd6   // nothing pending
    } key_t;

    // upper bit set means move mode
    typedef enum logic [1:0] {
        CHOOSE     = 2'b00,
        MOVE_TOTAL = 2'b10,
        MOVE_HALF  = 2'b11
    } cursor_mode_t;

    typedef enum logic [2:0] {READY, IN_ROUND, CHECK_WIN, ROUND_SWITCH, GAME_OVER} game_state_t;

    typedef enum logic [1:0] {MOVE_BLOCKED, MOVE_PEACEFUL, MOVE_ATTACK} move_result_t;

    typedef struct packed {
        player_t owner;
        piece_t  piece;
    } cell_t;

endpackage

// ==== design/board_if.sv ====
`timescale 1ns/10ps

interface board_if import game_pkg::*; #(
    parameter int TROOP_W = game_pkg::TROOP_W
);

    logic [POS_W-1:0]   cur_h, cur_v;        // cursor cell
    player_t            cur_owner;
    logic [TROOP_W-1:0] cur_troop;
    logic [POS_W-1:0]   host_h, host_v;      // host read window
    cell_t              host_cell;
    logic [TROOP_W-1:0] host_troop;
    logic               move_req;
    logic [POS_W-1:0]   move_h, move_v;      // move target
    logic               half;
    move_result_t       move_result;
    logic               load_layout;
    logic               grow;
    logic               grow_all;
    player_t            current_player;
    logic               red_crown_lost;
    logic               blue_crown_lost;

    modport ctrl (
        output cur_h, cur_v, move_req, move_h, move_v, half,
        output load_layout, grow, grow_all, current_player,
        input  cur_owner, cur_troop, move_result, red_crown_lost, blue_crown_lost
    );

    modport store (
        input  cur_h, cur_v, host_h, host_v, move_req, move_h, move_v, half,
        input  load_layout, grow, grow_all, current_player,
        output cur_owner, cur_troop, host_cell, host_troop, move_result,
        output red_crown_lost, blue_crown_lost
    );

    modport host (output host_h, host_v, input host_cell, host_troop);

endinterface

// ==== design/board_store.sv ====
`timescale 1ns/10ps

module board_store import game_pkg::*; #(
    parameter int TROOP_W = game_pkg::TROOP_W
) (
    input logic    clk_100M,
    input logic    reset,
    board_if.store board
);

    localparam logic [TROOP_W-1:0] RED_CROWN_TROOP  = TROOP_W'(87);
    localparam logic [TROOP_W-1:0] BLUE_CROWN_TROOP = TROOP_W'(89);
    localparam logic [TROOP_W-1:0] RED_CITY_TROOP   = TROOP_W'(25);

    cell_t              cells  [BOARD_W][BOARD_W];  // owner and piece
    logic [TROOP_W-1:0] troops [BOARD_W][BOARD_W];

    cell_t              dst_cell;
    logic [TROOP_W-1:0] src_troop;
    logic [TROOP_W-1:0] dst_troop;
    logic [TROOP_W-1:0] sent;        // troops leaving the cursor cell
    logic               own_target;
    logic               capture;

    // opening layout, earlier rules take precedence
    function automatic cell_t layout_cell(int h, int v);
        if (h == RED_CROWN_H && v == RED_CROWN_V) begin
            return '{owner: RED, piece: CROWN};
        end else if (h == BLUE_CROWN_H && v == BLUE_CROWN_V) begin
            return '{owner: BLUE, piece: CROWN};
        end else if (v == 5) begin
            return '{owner: NPC, piece: CITY};      // neutral city row
        end else if (h + v == 9 && h >= 6) begin
            return '{owner: NPC, piece: MOUNTAIN};
        end else if (h >= 2 && h <= 5 && v >= 2 && v <= 5) begin
            return '{owner: RED, piece: CITY};
        end
        return '{owner: NPC, piece: TERRITORY};
    endfunction

    function automatic logic [TROOP_W-1:0] layout_troop(cell_t c);
        if (c.piece == CROWN) begin
            return (c.owner == RED) ? RED_CROWN_TROOP : BLUE_CROWN_TROOP;
        end else if (c.piece == CITY && c.owner == RED) begin
            return RED_CITY_TROOP;
        end
        return '0;
    endfunction

    function automatic logic grows(cell_t c, logic all_cells);
        return c.owner != NPC && (all_cells || c.piece == CITY || c.piece == CROWN);
    endfunction

    assign dst_cell   = cells[board.move_h][board.move_v];
    assign src_troop  = troops[board.cur_h][board.cur_v];
    assign dst_troop  = troops[board.move_h][board.move_v];
    assign sent       = board.half ? src_troop >> 1 : src_troop - 1'b1;
    assign own_target = dst_cell.owner == board.current_player;
    assign capture    = !own_target && sent > dst_troop;  // strictly more wins

    assign board.cur_owner  = cells[board.cur_h][board.cur_v].owner;
    assign board.cur_troop  = src_troop;
    assign board.host_cell  = cells[board.host_h][board.host_v];
    assign board.host_troop = troops[board.host_h][board.host_v];

    assign board.red_crown_lost  = cells[RED_CROWN_H][RED_CROWN_V].owner != RED;
    assign board.blue_crown_lost = cells[BLUE_CROWN_H][BLUE_CROWN_V].owner != BLUE;

    always_comb begin
        if (dst_cell.piece == MOUNTAIN) begin
            board.move_result = MOVE_BLOCKED;
        end else if (dst_cell.owner == NPC || own_target) begin
            board.move_result = MOVE_PEACEFUL;
        end else begin
            board.move_result = MOVE_ATTACK;   // enemy cell, may take a crown
        end
    end

    always_ff @(posedge clk_100M or posedge reset) begin
        if (reset) begin
            for (int h = 0; h < BOARD_W; h++) begin
                for (int v = 0; v < BOARD_W; v++) begin
                    cells[h][v] <= '{owner: NPC, piece: TERRITORY};
                end
            end
        end else if (board.load_layout) begin
            for (int h = 0; h < BOARD_W; h++) begin
                for (int v = 0; v < BOARD_W; v++) begin
                    cells[h][v] <= layout_cell(h, v);
                end
            end
        end else if (board.move_req && capture) begin
            cells[board.move_h][board.move_v].owner <= board.current_player;
        end
    end

    // move and growth never come in the same cycle
    always_ff @(posedge clk_100M) begin
        if (board.load_layout) begin
            for (int h = 0; h < BOARD_W; h++) begin
                for (int v = 0; v < BOARD_W; v++) begin
                    troops[h][v] <= layout_troop(layout_cell(h, v));
                end
            end
        end else if (board.move_req) begin
            troops[board.cur_h][board.cur_v] <= src_troop - sent;
            if (own_target) begin
                troops[board.move_h][board.move_v] <= dst_troop + sent;
            end else if (capture) begin
                troops[board.move_h][board.move_v] <= sent - dst_troop;  // survivors
            end else begin
                troops[board.move_h][board.move_v] <= dst_troop - sent;
            end
        end else if (board.grow) begin
            for (int h = 0; h < BOARD_W; h++) begin
                for (int v = 0; v < BOARD_W; v++) begin
                    if (grows(cells[h][v], board.grow_all)) begin
                        troops[h][v] <= troops[h][v] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== design/game_ctrl.sv ====
`timescale 1ns/10ps

module game_ctrl import game_pkg::*; (
    input  logic             clk_100M,
    input  logic             reset,
    input  logic             key_ready,
    input  logic [2:0]       key_data,
    output logic             key_read_fin,
    input  logic             start,
    board_if.ctrl            board,
    output game_state_t      state,
    output player_t          current_player,
    output player_t          winner,
    output cursor_mode_t     cursor_mode,
    output logic [POS_W-1:0] cursor_h,
    output logic [POS_W-1:0] cursor_v
);

    key_t              pending;     // last key not yet settled
    logic [STEP_W-1:0] step_cnt;
    logic [STEP_W-1:0] round_next;  // round count once this step is done
    logic              fsm_run;
    logic              tgt_ok;
    logic [POS_W-1:0]  tgt_h;
    logic [POS_W-1:0]  tgt_v;
    player_t           next_player;

    assign fsm_run     = !key_ready;   // key cycles only latch
    assign round_next  = (step_cnt + 1'b1) >> 1;
    assign next_player = (current_player == RED) ? BLUE : RED;

    // neighbour cell of the pending WASD key, valid only inside the board
    always_comb begin
        tgt_ok = 1'b0;
        tgt_h  = cursor_h;
        tgt_v  = cursor_v;
        case (pending)
            KEY_W: begin
                tgt_ok = cursor_v != '0;
                tgt_v  = tgt_ok ? cursor_v - 1'b1 : cursor_v;
            end
            KEY_A: begin
                tgt_ok = cursor_h != '0;
                tgt_h  = tgt_ok ? cursor_h - 1'b1 : cursor_h;
            end
            KEY_S: begin
                tgt_ok = cursor_v != POS_W'(BOARD_W - 1);
                tgt_v  = tgt_ok ? cursor_v + 1'b1 : cursor_v;
            end
            KEY_D: begin
                tgt_ok = cursor_h != POS_W'(BOARD_W - 1);
                tgt_h  = tgt_ok ? cursor_h + 1'b1 : cursor_h;
            end
            default: ;
        endcase
    end

    assign board.cur_h          = cursor_h;
    assign board.cur_v          = cursor_v;
    assign board.move_h         = tgt_h;
    assign board.move_v         = tgt_v;
    assign board.half           = cursor_mode == MOVE_HALF;
    assign board.current_player = current_player;
    assign board.load_layout    = fsm_run && state == READY && start;
    assign board.move_req       = fsm_run && state == IN_ROUND && cursor_mode != CHOOSE
                                  && tgt_ok && board.move_result != MOVE_BLOCKED;
    // growth at the end of every full round
    assign board.grow     = fsm_run && state == ROUND_SWITCH && step_cnt[0];
    assign board.grow_all = round_next[GROWTH_PERIOD_LOG2-1:0] == '0;

    always_ff @(posedge clk_100M or posedge reset) begin
        if (reset) begin
            key_read_fin   <= 1'b0;
            pending        <= KEY_NONE;
            state          <= READY;
            current_player <= NPC;
            winner         <= NPC;
            cursor_mode    <= CHOOSE;
            cursor_h       <= '0;
            cursor_v       <= '0;
            step_cnt       <= '0;
        end else begin
            key_read_fin <= key_ready;   // held while the source holds ready
            if (key_ready) begin
                if (key_data <= 3'd5) begin
                    pending <= key_t'(key_data);   // overwrites an unsettled key
                end
            end else begin
                case (state)
                    READY: if (start) begin
                        state          <= IN_ROUND;
                        pending        <= KEY_NONE;
                        current_player <= RED;      // red opens
                        winner         <= NPC;
                        cursor_mode    <= CHOOSE;
                        cursor_h       <= RED_CROWN_H;
                        cursor_v       <= RED_CROWN_V;
                        step_cnt       <= '0;
                    end
                    IN_ROUND: if (pending != KEY_NONE) begin
                        pending <= KEY_NONE;
                        if (cursor_mode == CHOOSE) begin
                            if (tgt_ok) begin
                                cursor_h <= tgt_h;
                                cursor_v <= tgt_v;
                            end else if (pending == KEY_SPACE
                                         && board.cur_owner == current_player
                                         && board.cur_troop >= 2) begin
                                cursor_mode <= MOVE_TOTAL;
                            end
                        end else if (pending == KEY_Z) begin
                            cursor_mode <= (cursor_mode == MOVE_TOTAL) ? MOVE_HALF : MOVE_TOTAL;
                        end else if (pending == KEY_SPACE) begin
                            cursor_mode <= CHOOSE;
                        end else if (board.move_req) begin
                            state <= (board.move_result == MOVE_ATTACK) ? CHECK_WIN : ROUND_SWITCH;
                        end
                    end
                    CHECK_WIN: begin
                        if (board.red_crown_lost) begin
                            winner <= BLUE;
                            state  <= GAME_OVER;
                        end else if (board.blue_crown_lost) begin
                            winner <= RED;
                            state  <= GAME_OVER;
                        end else begin
                            state <= ROUND_SWITCH;
                        end
                    end
                    ROUND_SWITCH: begin
                        current_player <= next_player;
                        cursor_mode    <= CHOOSE;
                        cursor_h       <= (next_player == RED) ? RED_CROWN_H : BLUE_CROWN_H;
                        cursor_v       <= (next_player == RED) ? RED_CROWN_V : BLUE_CROWN_V;
                        step_cnt       <= step_cnt + 1'b1;
                        state          <= IN_ROUND;
                    end
                    GAME_OVER: pending <= KEY_NONE;  // keys are acked and dropped
                    default: state <= READY;
                endcase
            end
        end
    end

endmodule

// ==== design/game_regs.sv ====
`timescale 1ns/10ps

module game_regs import game_pkg::*; #(
    parameter int TROOP_W = game_pkg::TROOP_W
) (
    input  logic             clk_100M,
    input  logic             reset,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  logic [7:0]       wb_adr,
    input  logic [31:0]      wb_dat_i,
    output logic [31:0]      wb_dat_o,
    output logic             wb_ack,
    output logic             start,
    board_if.host            board,
    input  game_state_t      state,
    input  player_t          current_player,
    input  player_t          winner,
    input  cursor_mode_t     cursor_mode,
    input  logic [POS_W-1:0] cursor_h,
    input  logic [POS_W-1:0] cursor_v
);

    localparam logic [7:0] ADR_CTRL   = 8'd0;
    localparam logic [7:0] ADR_STATUS = 8'd1;

    logic        req;
    logic [6:0]  cell_idx;   // 10 cells per column so the board fits above 128
    logic        cell_hit;
    logic [31:0] rd_data;

    assign req      = wb_cyc && wb_stb && !wb_ack;
    assign cell_idx = wb_adr[6:0];
    assign cell_hit = wb_adr[7] && cell_idx < 7'd100;

    assign board.host_h = cell_hit ? POS_W'(cell_idx / 7'd10) : '0;
    assign board.host_v = cell_hit ? POS_W'(cell_idx % 7'd10) : '0;

    always_comb begin
        rd_data = '0;
        if (wb_adr == ADR_STATUS) begin
            rd_data[2:0]   = state;
            rd_data[5:4]   = current_player;
            rd_data[7:6]   = winner;
            rd_data[9:8]   = cursor_mode;
            rd_data[19:16] = cursor_h;
            rd_data[23:20] = cursor_v;
        end else if (cell_hit) begin
            rd_data[TROOP_W-1:0] = board.host_troop;
            rd_data[17:16]       = board.host_cell.piece;
            rd_data[25:24]       = board.host_cell.owner;
        end
    end

    always_ff @(posedge clk_100M or posedge reset) begin
        if (reset) begin
            wb_ack <= 1'b0;
            start  <= 1'b0;
        end else begin
            wb_ack <= req;                 // one cycle, masked while high
            start  <= req && wb_we && wb_adr == ADR_CTRL && wb_dat_i[0];
        end
    end

    always_ff @(posedge clk_100M) begin
        if (req) begin
            wb_dat_o <= rd_data;
        end
    end

endmodule

// ==== design/game_top.sv ====
`timescale 1ns/10ps

module game_top import game_pkg::*; #(
    parameter int TROOP_W = game_pkg::TROOP_W
) (
    input  logic        clk_100M,
    input  logic        reset,
    input  logic        key_ready,
    input  logic [2:0]  key_data,
    output logic        key_read_fin,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [7:0]  wb_adr,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack
);

    logic             start;
    game_state_t      state;
    player_t          current_player;
    player_t          winner;
    cursor_mode_t     cursor_mode;
    logic [POS_W-1:0] cursor_h;
    logic [POS_W-1:0] cursor_v;

    board_if #(.TROOP_W(TROOP_W)) board ();

    game_ctrl ctrl_i (
        .clk_100M       (clk_100M),
        .reset          (reset),
        .key_ready      (key_ready),
        .key_data       (key_data),
        .key_read_fin   (key_read_fin),
        .start          (start),
        .board          (board.ctrl),
        .state          (state),
        .current_player (current_player),
        .winner         (winner),
        .cursor_mode    (cursor_mode),
        .cursor_h       (cursor_h),
        .cursor_v       (cursor_v)
    );

    game_regs #(.TROOP_W(TROOP_W)) regs_i (
        .clk_100M       (clk_100M),
        .reset          (reset),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack         (wb_ack),
        .start          (start),
        .board          (board.host),
        .state          (state),
        .current_player (current_player),
        .winner         (winner),
        .cursor_mode    (cursor_mode),
        .cursor_h       (cursor_h),
        .cursor_v       (cursor_v)
    );

    board_store #(.TROOP_W(TROOP_W)) store_i (
        .clk_100M (clk_100M),
        .reset    (reset),
        .board    (board.store)
    );

endmodule

// ==== verif/game_sva.sv ====
`timescale 1ns/10ps

module game_sva import game_pkg::*; (
    input logic        clk_100M,
    input logic        reset,
    input logic        wb_ack,
    input logic        key_ready,
    input logic        key_read_fin,
    input game_state_t state
);

    ack_one_cycle: assert property (@(posedge clk_100M) disable iff (reset)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held for more than one cycle");

    // fin is only ever the echo of ready one cycle later
    fin_follows_ready: assert property (@(posedge clk_100M) disable iff (reset)
        key_read_fin |-> $past(key_ready))
        else $error("key_read_fin without key_ready in the cycle before");

    check_win_once: assert property (@(posedge clk_100M) disable iff (reset)
        state == CHECK_WIN |=> state != CHECK_WIN)
        else $error("state stuck in CHECK_WIN");

    round_switch_once: assert property (@(posedge clk_100M) disable iff (reset)
        state == ROUND_SWITCH |=> state != ROUND_SWITCH)
        else $error("state stuck in ROUND_SWITCH");

endmodule

// ==== verif/game_model.svh ====
`ifndef GAME_MODEL_SVH
`define GAME_MODEL_SVH

player_t      m_owner [BOARD_W][BOARD_W];
piece_t       m_piece [BOARD_W][BOARD_W];
int           m_troop [BOARD_W][BOARD_W];
game_state_t  m_state;
player_t      m_player;
player_t      m_winner;
cursor_mode_t m_mode;
int           m_h;
int           m_v;
int           m_step;

localparam int TROOP_MASK = (1 << TROOP_W) - 1;

function automatic void model_reset();
    m_state  = READY;
    m_player = NPC;
    m_winner = NPC;
    m_mode   = CHOOSE;
    m_h      = 0;
    m_v      = 0;
    m_step   = 0;
endfunction

// opening layout, first matching rule wins
function automatic void model_start();
    for (int h = 0; h < BOARD_W; h++) begin
        for (int v = 0; v < BOARD_W; v++) begin
            m_owner[h][v] = NPC;
            m_piece[h][v] = TERRITORY;
            m_troop[h][v] = 0;
            if (h == 2 && v == 3) begin
                m_owner[h][v] = RED;
                m_piece[h][v] = CROWN;
                m_troop[h][v] = 87;
            end else if (h == 8 && v == 7) begin
                m_owner[h][v] = BLUE;
                m_piece[h][v] = CROWN;
                m_troop[h][v] = 89;
            end else if (v == 5) begin
                m_piece[h][v] = CITY;
            end else if (h + v == 9 && h >= 6) begin
                m_piece[h][v] = MOUNTAIN;
            end else if (h >= 2 && h <= 5 && v >= 2 && v <= 5) begin
                m_owner[h][v] = RED;
                m_piece[h][v] = CITY;
                m_troop[h][v] = 25;
            end
        end
    end
    m_state  = IN_ROUND;
    m_player = RED;
    m_winner = NPC;
    m_mode   = CHOOSE;
    m_h      = 2;
    m_v      = 3;
    m_step   = 0;
endfunction

function automatic void model_grow(bit all_cells);
    for (int h = 0; h < BOARD_W; h++) begin
        for (int v = 0; v < BOARD_W; v++) begin
            if (m_owner[h][v] != NPC
                && (all_cells || m_piece[h][v] == CITY || m_piece[h][v] == CROWN)) begin
                m_troop[h][v] = (m_troop[h][v] + 1) & TROOP_MASK;
            end
        end
    end
endfunction

function automatic void model_switch();
    if (m_step % 2 == 1) begin
        model_grow(((m_step + 1) / 2) % 16 == 0);   // end of a full round
    end
    m_step   = m_step + 1;
    m_player = (m_player == RED) ? BLUE : RED;
    m_h      = (m_player == RED) ? 2 : 8;
    m_v      = (m_player == RED) ? 3 : 7;
    m_mode   = CHOOSE;
endfunction

function automatic void model_move(int th, int tv);
    int src;
    int sent;
    src  = m_troop[m_h][m_v];
    sent = (m_mode == MOVE_HALF) ? src / 2 : src - 1;
    m_troop[m_h][m_v] = src - sent;
    if (m_owner[th][tv] == m_player) begin
        m_troop[th][tv] = (m_troop[th][tv] + sent) & TROOP_MASK;
    end else if (sent > m_troop[th][tv]) begin
        m_troop[th][tv] = sent - m_troop[th][tv];   // capture
        m_owner[th][tv] = m_player;
    end else begin
        m_troop[th][tv] = m_troop[th][tv] - sent;
    end
    if (m_owner[2][3] != RED) begin
        m_winner = BLUE;
        m_state  = GAME_OVER;
    end else if (m_owner[8][7] != BLUE) begin
        m_winner = RED;
        m_state  = GAME_OVER;
    end else begin
        model_switch();
    end
endfunction

function automatic void model_key(int code);
    int th;
    int tv;
    bit ok;
    if (code > 5 || m_state != IN_ROUND) begin
        return;
    end
    th = m_h;
    tv = m_v;
    ok = 0;
    case (code)
        0: if (m_v > 0) begin
            ok = 1;
            tv = m_v - 1;
        end
        1: if (m_h > 0) begin
            ok = 1;
            th = m_h - 1;
        end
        2: if (m_v < BOARD_W - 1) begin
            ok = 1;
            tv = m_v + 1;
        end
        3: if (m_h < BOARD_W - 1) begin
            ok = 1;
            th = m_h + 1;
        end
        default: ;
    endcase
    if (m_mode == CHOOSE) begin
        if (ok) begin
            m_h = th;
            m_v = tv;
        end else if (code == 4 && m_owner[m_h][m_v] == m_player && m_troop[m_h][m_v] >= 2) begin
            m_mode = MOVE_TOTAL;
        end
    end else if (code == 5) begin
        m_mode = (m_mode == MOVE_TOTAL) ? MOVE_HALF : MOVE_TOTAL;
    end else if (code == 4) begin
        m_mode = CHOOSE;
    end else if (ok && m_piece[th][tv] != MOUNTAIN) begin
        model_move(th, tv);
    end
endfunction

function automatic logic [31:0] status_word();
    logic [31:0] w;
    w        = '0;
    w[2:0]   = m_state;
    w[5:4]   = m_player;
    w[7:6]   = m_winner;
    w[9:8]   = m_mode;
    w[19:16] = m_h[3:0];
    w[23:20] = m_v[3:0];
    return w;
endfunction

`endif

// ==== verif/game_tb.sv ====
`timescale 1ns/10ps

module game_tb import game_pkg::*; ();

    localparam int KEY_BUDGET     = 900;               // upper bound of keys over all tests
    localparam int TIMEOUT_CYCLES = KEY_BUDGET * 30;

    logic        clk_100M;
    logic        reset;
    logic        key_ready;
    logic [2:0]  key_data;
    logic        key_read_fin;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [7:0]  wb_adr;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack;

    int checks;
    int errors;
    int cycles;

    `include "game_model.svh"

    game_top #(.TROOP_W(TROOP_W)) dut_i (.*);

    bind game_top game_sva sva_i (
        .clk_100M     (clk_100M),
        .reset        (reset),
        .wb_ack       (wb_ack),
        .key_ready    (key_ready),
        .key_read_fin (key_read_fin),
        .state        (state)
    );

    initial begin
        clk_100M = 1'b0;
        forever #5 clk_100M = ~clk_100M;
    end

    always @(posedge clk_100M) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: no end of run after %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] data);
        @(posedge clk_100M);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_i = data;
        @(posedge clk_100M);
        #1;
        while (!wb_ack) begin
            @(posedge clk_100M);
            #1;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] data);
        @(posedge clk_100M);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        @(posedge clk_100M);
        #1;
        while (!wb_ack) begin
            @(posedge clk_100M);
            #1;
        end
        data = wb_dat_o;   // stable through the ack cycle
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic check_status();
        logic [31:0] got;
        wb_read(8'd1, got);
        check_value("status", got, status_word());
    endtask

    task automatic check_cell(input int h, input int v);
        logic [31:0] got;
        wb_read(8'(128 + 10 * h + v), got);
        check_value($sformatf("troop[%0d][%0d]", h, v), got[8:0], m_troop[h][v]);
        check_value($sformatf("piece[%0d][%0d]", h, v), got[17:16], m_piece[h][v]);
        check_value($sformatf("owner[%0d][%0d]", h, v), got[25:24], m_owner[h][v]);
    endtask

    task automatic check_board();
        for (int h = 0; h < BOARD_W; h++) begin
            for (int v = 0; v < BOARD_W; v++) begin
                check_cell(h, v);
            end
        end
    endtask

    // full handshake, then settle time before the status is read back
    task automatic press_key(input int code);
        @(posedge clk_100M);
        #1;
        key_ready = 1'b1;
        key_data  = code[2:0];
        @(posedge clk_100M);
        #1;
        while (!key_read_fin) begin
            @(posedge clk_100M);
            #1;
        end
        key_ready = 1'b0;
        repeat (4) @(posedge clk_100M);
        model_key(code);
        check_status();
        check_cell(m_h, m_v);
    endtask

    task automatic goto_cell(input int h, input int v);
        while (m_h < h) press_key(KEY_D);
        while (m_h > h) press_key(KEY_A);
        while (m_v < v) press_key(KEY_S);
        while (m_v > v) press_key(KEY_W);
    endtask

    task automatic steer_move(input int h, input int v, input int dir, input bit half);
        goto_cell(h, v);
        press_key(KEY_SPACE);
        if (half) begin
            press_key(KEY_Z);
        end
        press_key(dir);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) @(posedge clk_100M);
        #1;
        reset = 1'b0;
        model_reset();
    endtask

    task automatic new_game();
        apply_reset();
        wb_write(8'd0, 32'h1);
        repeat (2) @(posedge clk_100M);
        model_start();
    endtask

    task automatic report(input int num, input string what, input int errs_before);
        $display("[%0d] %s finished, %0d mismatches", num, what, errors - errs_before);
    endtask

    initial begin
        int          e0;
        int          code;
        logic [31:0] got;
        int          red_h [10] = '{2, 3, 4, 5, 5, 5, 5, 5, 6, 7};
        int          red_v [10] = '{3, 3, 3, 3, 4, 5, 6, 7, 7, 7};
        int          red_d [10] = '{3, 3, 3, 2, 2, 2, 2, 3, 3, 3};

        reset     = 1'b1;
        key_ready = 1'b0;
        key_data  = '0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_i  = '0;
        checks    = 0;
        errors    = 0;
        cycles    = 0;
        void'($urandom(32'hdc7d));

        e0 = errors;
        apply_reset();
        check_status();
        wb_write(8'd0, 32'h1);
        repeat (2) @(posedge clk_100M);
        model_start();
        check_board();
        check_status();
        report(1, "reset and layout", e0);

        e0 = errors;
        for (int i = 0; i < 60; i++) begin
            code = $urandom % 6;
            press_key(code < 4 ? code : code + 2);   // WASD or the unused codes
        end
        report(2, "cursor walk", e0);

        e0 = errors;
        goto_cell(0, 0);
        press_key(KEY_SPACE);        // npc cell, stays in choose
        goto_cell(2, 3);
        press_key(KEY_SPACE);
        press_key(KEY_Z);
        press_key(KEY_Z);
        press_key(KEY_SPACE);
        goto_cell(8, 7);
        press_key(KEY_SPACE);        // blue crown on red's turn
        goto_cell(3, 4);
        press_key(KEY_SPACE);
        press_key(KEY_Z);
        press_key(KEY_SPACE);
        report(3, "mode switching", e0);

        e0 = errors;
        for (int i = 0; i < 400; i++) begin
            press_key($urandom % 8);
        end
        check_board();
        report(4, "random play", e0);

        e0 = errors;
        new_game();
        for (int r = 0; r < 17; r++) begin
            steer_move(2, (r % 2 == 0) ? 3 : 2, (r % 2 == 0) ? KEY_W : KEY_S, 1'b0);
            steer_move(8, (r % 2 == 0) ? 7 : 8, (r % 2 == 0) ? KEY_S : KEY_W, 1'b0);
        end
        check_board();
        report(5, "growth", e0);

        e0 = errors;
        new_game();
        for (int i = 0; i < 10; i++) begin
            steer_move(red_h[i], red_v[i], red_d[i], 1'b0);
            if (i == 0) begin
                steer_move(8, 7, KEY_S, 1'b0);  // blue drains its own crown
            end else if (i < 9) begin
                steer_move(8, (i % 2 == 1) ? 8 : 9, (i % 2 == 1) ? KEY_S : KEY_W, 1'b0);
            end
        end
        wb_read(8'd1, got);
        check_value("state", got[2:0], GAME_OVER);
        check_value("winner", got[7:6], RED);
        for (int i = 0; i < 10; i++) begin
            press_key($urandom % 8);
        end
        wb_read(8'd1, got);
        check_value("state", got[2:0], GAME_OVER);
        check_value("winner", got[7:6], RED);
        report(6, "crown capture", e0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== game_top.f ====
+incdir+verif
design/game_pkg.sv
design/board_if.sv
design/board_store.sv
design/game_ctrl.sv
design/game_regs.sv
design/game_top.sv
verif/game_sva.sv
verif/game_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module game_tb -f game_top.f -o game_sim
	./obj_dir/game_sim | tee /dev/stderr | grep -qx "test passed"

clean:
	rm -rf obj_dir
